//--- logic/memCtrlPkg.sv
`default_nettype none

package memCtrlPkg;

  ////////////////////////////////////////
  // widths with a meaning
  ////////////////////////////////////////
  typedef logic [15:0] wordT;     // uart word, sram data word or tag
  typedef logic [7:0]  byteT;     // one uart byte
  typedef logic [21:0] sramAddrT; // external sram address

  ////////////////////////////////////////
  // command tags from the host
  ////////////////////////////////////////
  localparam wordT initTag       = 16'hAAAA;
  localparam wordT camTag        = 16'hBBBB;
  localparam wordT objTag        = 16'hEEEE;
  localparam wordT vtxTag        = 16'h9999; // count follows, then address
  localparam wordT closeObjTag   = 16'h8888;
  localparam wordT finalBlockTag = 16'hFFFF; // written one past each block

  // data words per fixed-size block
  localparam wordT initBlockSize     = 16'd2;
  localparam wordT camBlockSize      = 16'd5;
  localparam wordT objBlockSize      = 16'd13;
  localparam wordT closeObjBlockSize = 16'd1;

  // command sequencer states
  typedef enum logic [2:0] {
    idle,
    sendAck,    // inverted tag goes out
    getCount,   // vertex blocks only
    getAddr,
    writeData,
    writeFinal, // end-of-block tag
    sendEcho
  } seqStateT;

endpackage

`default_nettype wire

//--- logic/sramReqIf.sv
`default_nettype none

// write requests from the sequencer into the sram queue
interface sramReqIf;
  import memCtrlPkg::*;

  wordT addr;  // internal word address
  wordT data;
  logic valid; // held with addr/data until ready
  logic ready; // low while the queue is full

  modport source (
    output addr,
    output data,
    output valid,
    input  ready
  );

  modport sink (
    input  addr,
    input  data,
    input  valid,
    output ready
  );

endinterface

`default_nettype wire

//--- logic/uartWordRx.sv
`default_nettype none

module uartWordRx (
  input  wire logic             iValidRead,
  input  wire logic             rstN,
  input  wire memCtrlPkg::byteT rxByte,
  input  wire logic             rxReady,
  input  wire logic             rxError,
  output memCtrlPkg::wordT      rxWord,
  output logic                  rxWordValid
);
  import memCtrlPkg::*;

  byteT hiByte;  // first byte of the word
  logic pending; // high half already collected

  // pairing control
  always_ff @(posedge iValidRead or negedge rstN) begin
    if (!rstN) begin
      pending     <= 1'b0;
      rxWordValid <= 1'b0;
    end else begin
      rxWordValid <= 1'b0;
      if (rxError) begin
        pending <= 1'b0; // drop the half word, restart on next byte
      end else if (rxReady) begin
        pending     <= !pending;
        rxWordValid <= pending; // second byte completes the word
      end
    end
  end

  // byte capture, high byte first
  always_ff @(posedge iValidRead) begin
    if (rxReady && !rxError) begin
      if (pending) begin
        rxWord <= {hiByte, rxByte};
      end else begin
        hiByte <= rxByte;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/cmdSequencer.sv
`default_nettype none

module cmdSequencer (
  input  wire logic             iValidRead,
  input  wire logic             rstN,
  input  wire memCtrlPkg::wordT rxWord,
  input  wire logic             rxWordValid,
  sramReqIf.source              sramReq,
  output memCtrlPkg::wordT      txWord,
  output logic                  txWordValid,
  input  wire logic             txBusy
);
  import memCtrlPkg::*;

  seqStateT state;
  wordT     tagReg;  // command being served, sent back as echo
  wordT     remain;  // data words still expected
  wordT     curAddr; // next data word address
  wordT     tagSize;
  logic     tagKnown;
  logic     txTake;
  logic     wrDone;

  assign txTake = txWordValid && !txBusy;
  assign wrDone = sramReq.valid && sramReq.ready;

  ////////////////////////////////////////
  // tag decode
  ////////////////////////////////////////
  always_comb begin
    tagKnown = 1'b1;
    tagSize  = '0;
    case (rxWord)
      initTag:     tagSize = initBlockSize;
      camTag:      tagSize = camBlockSize;
      objTag:      tagSize = objBlockSize;
      closeObjTag: tagSize = closeObjBlockSize;
      vtxTag:      tagSize = '0; // host supplies the count
      default:     tagKnown = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // state machine and counters
  ////////////////////////////////////////
  always_ff @(posedge iValidRead or negedge rstN) begin
    if (!rstN) begin
      state         <= idle;
      sramReq.valid <= 1'b0;
      txWordValid   <= 1'b0;
      remain        <= '0;
      curAddr       <= '0;
    end else begin
      case (state)
        idle: begin
          if (rxWordValid && tagKnown) begin // unknown words ignored
            remain      <= tagSize;
            txWordValid <= 1'b1;
            state       <= sendAck;
          end
        end
        sendAck: begin
          if (txTake) begin
            txWordValid <= 1'b0;
            state       <= (tagReg == vtxTag) ? getCount : getAddr;
          end
        end
        getCount: begin
          if (rxWordValid) begin
            remain <= rxWord;
            state  <= getAddr;
          end
        end
        getAddr: begin
          if (rxWordValid) begin
            curAddr <= rxWord;
            if (remain == '0) begin
              sramReq.valid <= 1'b1; // empty block, final tag at base
              state         <= writeFinal;
            end else begin
              state <= writeData;
            end
          end
        end
        writeData: begin
          if (rxWordValid) begin
            sramReq.valid <= 1'b1;
            curAddr       <= curAddr + 1'b1;
            remain        <= remain - 1'b1;
          end else if (wrDone) begin
            if (remain == '0) begin
              state <= writeFinal; // valid stays up for the final tag
            end else begin
              sramReq.valid <= 1'b0;
            end
          end
        end
        writeFinal: begin
          if (wrDone) begin
            sramReq.valid <= 1'b0;
            txWordValid   <= 1'b1;
            state         <= sendEcho;
          end
        end
        sendEcho: begin
          if (txTake) begin
            txWordValid <= 1'b0;
            state       <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // reply and write payload, same conditions as above
  always_ff @(posedge iValidRead) begin
    if (state == idle && rxWordValid && tagKnown) begin
      tagReg <= rxWord;
      txWord <= ~rxWord; // ack is the inverted tag
    end else if (state == writeFinal && wrDone) begin
      txWord <= tagReg;
    end

    if (state == getAddr && rxWordValid) begin
      sramReq.addr <= rxWord;
      sramReq.data <= finalBlockTag;
    end else if (state == writeData && rxWordValid) begin
      sramReq.addr <= curAddr;
      sramReq.data <= rxWord;
    end else if (state == writeData && wrDone && remain == '0) begin
      sramReq.addr <= curAddr; // base plus block size
      sramReq.data <= finalBlockTag;
    end
  end

endmodule

`default_nettype wire

//--- logic/sramWriter.sv
`default_nettype none

module sramWriter #(
  parameter int queueDepth = 2
) (
  input  wire logic         iValidRead,
  input  wire logic         rstN,
  sramReqIf.sink            sramReq,
  output memCtrlPkg::sramAddrT sramAddr,
  output memCtrlPkg::wordT  sramData,
  output logic              sramReqOut,
  input  wire logic         sramAck
);
  import memCtrlPkg::*;

  localparam int ptrW = $clog2(queueDepth);
  localparam int cntW = $clog2(queueDepth + 1);

  typedef logic [ptrW-1:0] ptrT;

  wordT            qAddr [queueDepth];
  wordT            qData [queueDepth];
  ptrT             wrPtr;
  ptrT             rdPtr;
  logic [cntW-1:0] count;
  logic            push;
  logic            pop;

  function automatic ptrT nextPtr(ptrT p);
    return (p == ptrT'(queueDepth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign sramReq.ready = (count != cntW'(queueDepth));
  assign push          = sramReq.valid && sramReq.ready;
  assign pop           = sramReqOut && sramAck;

  // oldest entry on the pins
  assign sramAddr = sramAddrT'(qAddr[rdPtr]); // zero-extended
  assign sramData = qData[rdPtr];

  always_ff @(posedge iValidRead or negedge rstN) begin
    if (!rstN) begin
      wrPtr      <= '0;
      rdPtr      <= '0;
      count      <= '0;
      sramReqOut <= 1'b0;
    end else begin
      if (push) wrPtr <= nextPtr(wrPtr);
      if (pop) rdPtr <= nextPtr(rdPtr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      // request drops for a cycle after every ack
      if (pop) begin
        sramReqOut <= 1'b0;
      end else if (!sramReqOut && count != '0) begin
        sramReqOut <= 1'b1;
      end
    end
  end

  always_ff @(posedge iValidRead) begin
    if (push) begin
      qAddr[wrPtr] <= sramReq.addr;
      qData[wrPtr] <= sramReq.data;
    end
  end

endmodule

`default_nettype wire

//--- logic/uartWordTx.sv
`default_nettype none

module uartWordTx (
  input  wire logic             iValidRead,
  input  wire logic             rstN,
  input  wire memCtrlPkg::wordT txWord,
  input  wire logic             txWordValid,
  output logic                  txBusy,
  output memCtrlPkg::byteT      txByte,
  output logic                  txReady,
  input  wire logic             txSent
);
  import memCtrlPkg::*;

  typedef enum logic [1:0] {
    txIdle,
    txHigh, // high byte on txByte
    txLow
  } txStateT;

  txStateT state;
  byteT    lowByte; // held until the first byte is sent
  logic    take;

  assign take    = txWordValid && !txBusy;
  assign txReady = (state != txIdle);
  assign txBusy  = (state != txIdle); // covers both bytes

  ////////////////////////////////////////
  // two-phase sender
  ////////////////////////////////////////
  always_ff @(posedge iValidRead or negedge rstN) begin
    if (!rstN) begin
      state <= txIdle;
    end else begin
      case (state)
        txIdle: if (take) state <= txHigh;
        txHigh: if (txSent) state <= txLow;
        txLow:  if (txSent) state <= txIdle;
        default: state <= txIdle;
      endcase
    end
  end

  always_ff @(posedge iValidRead) begin
    if (take) begin
      txByte  <= txWord[15:8];
      lowByte <= txWord[7:0];
    end else if (state == txHigh && txSent) begin
      txByte <= lowByte; // txReady stays up across the switch
    end
  end

endmodule

`default_nettype wire

//--- logic/memCtrlTop.sv
`default_nettype none

module memCtrlTop #(
  parameter int queueDepth = 2
) (
  input  wire logic             iValidRead,
  input  wire logic             rstN,
  // uart
  input  wire memCtrlPkg::byteT rxByte,
  input  wire logic             rxReady,
  input  wire logic             rxError,
  input  wire logic             txSent,
  output memCtrlPkg::byteT      txByte,
  output logic                  txReady,
  // sram
  output memCtrlPkg::sramAddrT  sramAddr,
  output memCtrlPkg::wordT      sramData,
  output logic                  sramReq,
  input  wire logic             sramAck
);
  import memCtrlPkg::*;

  wordT rxWord;
  logic rxWordValid;
  wordT txWord;
  logic txWordValid;
  logic txBusy;

  sramReqIf reqIf ();

  uartWordRx rx0 (
    .iValidRead  (iValidRead),
    .rstN        (rstN),
    .rxByte      (rxByte),
    .rxReady     (rxReady),
    .rxError     (rxError),
    .rxWord      (rxWord),
    .rxWordValid (rxWordValid)
  );

  cmdSequencer seq0 (
    .iValidRead  (iValidRead),
    .rstN        (rstN),
    .rxWord      (rxWord),
    .rxWordValid (rxWordValid),
    .sramReq     (reqIf.source),
    .txWord      (txWord),
    .txWordValid (txWordValid),
    .txBusy      (txBusy)
  );

  sramWriter #(
    .queueDepth (queueDepth)
  ) writer0 (
    .iValidRead (iValidRead),
    .rstN       (rstN),
    .sramReq    (reqIf.sink),
    .sramAddr   (sramAddr),
    .sramData   (sramData),
    .sramReqOut (sramReq),
    .sramAck    (sramAck)
  );

  uartWordTx tx0 (
    .iValidRead  (iValidRead),
    .rstN        (rstN),
    .txWord      (txWord),
    .txWordValid (txWordValid),
    .txBusy      (txBusy),
    .txByte      (txByte),
    .txReady     (txReady),
    .txSent      (txSent)
  );

endmodule

`default_nettype wire

//--- verification/memCtrl_chk.sv
`default_nettype none

module memCtrlChk (
  input wire logic                 iValidRead,
  input wire logic                 rstN,
  input wire memCtrlPkg::sramAddrT sramAddr,
  input wire memCtrlPkg::wordT     sramData,
  input wire logic                 sramReq,
  input wire logic                 sramAck,
  input wire logic                 txReady,
  input wire logic                 txSent
);
  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////
  // sram request/acknowledge
  ////////////////////////////////////////
  reqHeld: assert property (@(posedge iValidRead) disable iff (!rstN)
    sramReq && !sramAck |=> sramReq && $stable(sramAddr) && $stable(sramData))
    else $error("sramReq dropped or its address/data changed before sramAck");

  // uart byte stays offered until sent
  txHeld: assert property (@(posedge iValidRead) disable iff (!rstN)
    txReady && !txSent |=> txReady)
    else $error("txReady dropped before txSent");

  resetQuiet: assert property (@(posedge iValidRead) !rstN |-> !sramReq && !txReady)
    else $error("sramReq or txReady high during reset");

endmodule

bind memCtrlTop memCtrlChk chk0 (
  .iValidRead (iValidRead),
  .rstN       (rstN),
  .sramAddr   (sramAddr),
  .sramData   (sramData),
  .sramReq    (sramReq),
  .sramAck    (sramAck),
  .txReady    (txReady),
  .txSent     (txSent)
);

`default_nettype wire

//--- verification/memCtrlTb.sv
`default_nettype none

module memCtrlTb;
  timeunit 1ns;
  timeprecision 1ps;
  import memCtrlPkg::*;

  localparam int totalWords = 44; // host words over all tests
  localparam int maxCycles  = 40 * totalWords * 16;

  logic     iValidRead = 1'b0;
  logic     rstN;
  byteT     rxByte;
  logic     rxReady;
  logic     rxError;
  logic     txSent;
  byteT     txByte;
  logic     txReady;
  sramAddrT sramAddr;
  wordT     sramData;
  logic     sramReq;
  logic     sramAck;

  int unsigned lcgState   = 80;
  int          errorCount = 0;
  int          checkCount = 0;
  int          testCount  = 0;
  int          cycleCount = 0;

  wordT     expAddrQ[$];  // filled by the reference, drained by compare
  wordT     expDataQ[$];
  wordT     expReplyQ[$];
  sramAddrT gotAddrQ[$];  // filled by the models
  wordT     gotDataQ[$];
  wordT     gotReplyQ[$];

  memCtrlTop #(.queueDepth(2)) dut0 (
    .iValidRead (iValidRead),
    .rstN       (rstN),
    .rxByte     (rxByte),
    .rxReady    (rxReady),
    .rxError    (rxError),
    .txSent     (txSent),
    .txByte     (txByte),
    .txReady    (txReady),
    .sramAddr   (sramAddr),
    .sramData   (sramData),
    .sramReq    (sramReq),
    .sramAck    (sramAck)
  );

  always #50 iValidRead = ~iValidRead;

  always @(posedge iValidRead) begin
    cycleCount++;
    if (cycleCount >= maxCycles) begin
      $display("timeout: the tests did not finish within %0d cycles", maxCycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState >> 16;
  endfunction

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  function automatic void expectedWrites(input wordT tag, input int count, input wordT base,
                                         input wordT data[$], output wordT addrs[$],
                                         output wordT datas[$], output wordT replies[$]);
    int size;
    case (tag)
      16'hAAAA: size = 2;  // init
      16'hBBBB: size = 5;  // camera
      16'hEEEE: size = 13; // object
      16'h8888: size = 1;  // close object
      default:  size = count; // vertex, host count
    endcase
    addrs   = {};
    datas   = {};
    replies = {};
    for (int i = 0; i < size; i++) begin
      addrs.push_back(base + wordT'(i));
      datas.push_back(data[i]);
    end
    addrs.push_back(base + wordT'(size)); // end-of-block marker
    datas.push_back(16'hFFFF);
    replies.push_back(~tag);
    replies.push_back(tag);
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // compare on the rising edge, models push on the falling edge
  always @(posedge iValidRead) begin
    while (gotAddrQ.size() > 0) begin
      if (expAddrQ.size() == 0) begin
        errorCount++;
        $display("unexpected sram write to address %h at %0d ns", gotAddrQ[0], $time);
      end else begin
        checkValue("sramAddr", 32'(expAddrQ.pop_front()), 32'(gotAddrQ[0]));
        checkValue("sramData", 32'(expDataQ.pop_front()), 32'(gotDataQ[0]));
      end
      void'(gotAddrQ.pop_front());
      void'(gotDataQ.pop_front());
    end
    while (gotReplyQ.size() > 0) begin
      if (expReplyQ.size() == 0) begin
        errorCount++;
        $display("unexpected reply word %h at %0d ns", gotReplyQ[0], $time);
      end else begin
        checkValue("reply word", 32'(expReplyQ.pop_front()), 32'(gotReplyQ[0]));
      end
      void'(gotReplyQ.pop_front());
    end
  end

  ////////////////////////////////////////
  // sram and uart reply models
  ////////////////////////////////////////
  initial begin : sramModel
    int delay;
    sramAck = 1'b0;
    forever begin
      @(negedge iValidRead);
      if (sramReq) begin
        delay = 1 + int'(nextRand() % 4); // 1 to 4 cycles
        repeat (delay - 1) @(negedge iValidRead);
        gotAddrQ.push_back(sramAddr);
        gotDataQ.push_back(sramData);
        sramAck = 1'b1;
        @(negedge iValidRead);
        sramAck = 1'b0;
      end
    end
  end

  initial begin : uartReplyModel
    byteT hi;
    byteT lo;
    txSent = 1'b0;
    forever begin
      @(negedge iValidRead);
      if (txReady) begin
        repeat (2) @(negedge iValidRead);
        hi     = txByte;
        txSent = 1'b1;
        @(negedge iValidRead);
        txSent = 1'b0;
        repeat (2) @(negedge iValidRead); // low byte is up by now
        lo     = txByte;
        txSent = 1'b1;
        @(negedge iValidRead);
        txSent = 1'b0;
        gotReplyQ.push_back({hi, lo});
      end
    end
  end

  ////////////////////////////////////////
  // host side
  ////////////////////////////////////////
  task automatic sendByte(input byteT b);
    rxByte  = b;
    rxReady = 1'b1;
    @(negedge iValidRead);
    rxReady = 1'b0;
    repeat (7) @(negedge iValidRead);
  endtask

  task automatic sendBadByte();
    rxError = 1'b1; // strobe in place of rxReady
    @(negedge iValidRead);
    rxError = 1'b0;
    repeat (7) @(negedge iValidRead);
  endtask

  task automatic sendWord(input wordT w);
    sendByte(w[15:8]);
    sendByte(w[7:0]);
  endtask

  task automatic waitDone();
    while (expAddrQ.size() != 0 || expReplyQ.size() != 0) begin
      @(negedge iValidRead);
    end
    repeat (20) @(negedge iValidRead); // room for stray writes or replies
  endtask

  task automatic runCommand(input wordT tag, input int nData, input wordT base);
    wordT data[$];
    wordT addrs[$];
    wordT datas[$];
    wordT replies[$];
    for (int i = 0; i < nData; i++) begin
      data.push_back(wordT'(nextRand()));
    end
    expectedWrites(tag, nData, base, data, addrs, datas, replies);
    expAddrQ  = {expAddrQ, addrs};
    expDataQ  = {expDataQ, datas};
    expReplyQ = {expReplyQ, replies};
    sendWord(tag);
    if (tag == vtxTag) begin
      sendWord(wordT'(nData));
    end
    sendWord(base);
    foreach (data[i]) begin
      sendWord(data[i]);
    end
    waitDone();
  endtask

  task automatic reportTest(input string name, input int startErrors);
    testCount++;
    if (errorCount == startErrors) begin
      $display("test %0d, %s: ok", testCount, name);
    end else begin
      $display("test %0d, %s: %0d errors", testCount, name, errorCount - startErrors);
    end
  endtask

  initial begin : mainSeq
    int startErr;
    rstN    = 1'b0;
    rxByte  = '0;
    rxReady = 1'b0;
    rxError = 1'b0;
    repeat (3) @(negedge iValidRead);
    rstN = 1'b1;
    repeat (2) @(negedge iValidRead);

    startErr = errorCount;
    runCommand(camTag, 5, 16'h0100);
    reportTest("camera block", startErr);

    startErr = errorCount;
    runCommand(initTag, 2, 16'h0200);
    runCommand(closeObjTag, 1, 16'h0300);
    reportTest("init and close object", startErr);

    startErr = errorCount;
    runCommand(vtxTag, 7, 16'h1000);
    reportTest("vertex block of 7", startErr);

    startErr = errorCount;
    sendWord(16'h1234); // not a tag, ignored in idle
    runCommand(objTag, 13, 16'h2000);
    reportTest("unknown word then object", startErr);

    startErr = errorCount;
    sendByte(8'h12);
    sendBadByte();
    runCommand(initTag, 2, 16'h3000);
    reportTest("receive error drops half word", startErr);

    $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
logic/memCtrlPkg.sv
logic/sramReqIf.sv
logic/uartWordRx.sv
logic/cmdSequencer.sv
logic/sramWriter.sv
logic/uartWordTx.sv
logic/memCtrlTop.sv
verification/memCtrl_chk.sv
verification/memCtrlTb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := memCtrlTb
FLIST      := flist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
